// File: logic/boot_cfg_pkg.sv
// boot config package: script step format, bus widths and step builders for the sequencer
package boot_cfg_pkg;

  // *********************************************************************
  // bus and counter widths
  // *********************************************************************
  localparam int addr_w = 32;
  localparam int data_w = 32;
  // wait step count, up to 65535 idle cycles
  localparam int wait_w = 16;

  // script length, trailing entries padded with op_end
  localparam int max_steps  = 10;
  localparam int step_idx_w = $clog2(max_steps);
  localparam logic [step_idx_w-1:0] last_step = step_idx_w'(max_steps - 1);

  // *********************************************************************
  // step record
  // *********************************************************************
  typedef enum logic [2:0] {
    op_write = 3'd0,
    op_rmw   = 3'd1,
    op_wait  = 3'd2,
    op_end   = 3'd3
  } step_op_t;

  // data is the write value, mask the rmw clear bits, count the idle cycles
  typedef struct packed {
    step_op_t            op;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   data;
    logic [data_w-1:0]   mask;
    logic [wait_w-1:0]   count;
  } step_t;

  typedef step_t script_t [max_steps];

  localparam step_t step_end = '{op: op_end, addr: '0, data: '0, mask: '0, count: '0};

  // builders used by the script tables
  function automatic step_t step_wr(input logic [addr_w-1:0] step_addr,
                                    input logic [data_w-1:0] step_data);
    step_wr = '{op: op_write, addr: step_addr, data: step_data, mask: '0, count: '0};
  endfunction

  function automatic step_t step_rmw(input logic [addr_w-1:0] step_addr,
                                     input logic [data_w-1:0] step_mask);
    step_rmw = '{op: op_rmw, addr: step_addr, data: '0, mask: step_mask, count: '0};
  endfunction

  function automatic step_t step_wait(input logic [wait_w-1:0] step_count);
    step_wait = '{op: op_wait, addr: '0, data: '0, mask: '0, count: step_count};
  endfunction

endpackage

// File: logic/boot_scripts_pkg.sv
// boot scripts package: power-on register scripts for the primary and secondary controllers
package boot_scripts_pkg;

  // *********************************************************************
  // primary controller registers
  // *********************************************************************
  localparam logic [boot_cfg_pkg::addr_w-1:0] pri_addr_cfg0    = 32'h0000_001c;
  localparam logic [boot_cfg_pkg::addr_w-1:0] pri_addr_cfg1    = 32'h0000_0020;
  localparam logic [boot_cfg_pkg::addr_w-1:0] pri_addr_timing  = 32'h0000_0004;
  // global interrupt enable
  localparam logic [boot_cfg_pkg::addr_w-1:0] pri_addr_intr_en = 32'h0000_0220;
  localparam logic [boot_cfg_pkg::addr_w-1:0] pri_addr_ctrl    = 32'h0000_0000;
  localparam logic [boot_cfg_pkg::addr_w-1:0] pri_addr_cmd     = 32'h0000_000c;

  localparam logic [boot_cfg_pkg::data_w-1:0] pri_val_cfg0    = 32'h0404_0400;
  localparam logic [boot_cfg_pkg::data_w-1:0] pri_val_cfg1    = 32'h0100_0101;
  localparam logic [boot_cfg_pkg::data_w-1:0] pri_val_timing  = 32'h8053_0000;
  localparam logic [boot_cfg_pkg::data_w-1:0] pri_val_intr_en = 32'h805d_0000;
  localparam logic [boot_cfg_pkg::data_w-1:0] pri_val_ctrl    = 32'hc000_0001;
  localparam logic [boot_cfg_pkg::data_w-1:0] pri_val_cmd     = 32'h4420_0383;

  // settle time after enable, before the command writes
  localparam logic [boot_cfg_pkg::wait_w-1:0] pri_boot_wait = 16'hffff;

  // *********************************************************************
  // secondary controller registers
  // *********************************************************************
  // clock divider
  localparam logic [boot_cfg_pkg::addr_w-1:0] sec_addr_div     = 32'h0000_00b0;
  localparam logic [boot_cfg_pkg::addr_w-1:0] sec_addr_mode_78 = 32'h0000_0078;
  localparam logic [boot_cfg_pkg::addr_w-1:0] sec_addr_mode_70 = 32'h0000_0070;
  localparam logic [boot_cfg_pkg::addr_w-1:0] sec_addr_stat    = 32'h0000_0074;
  localparam logic [boot_cfg_pkg::addr_w-1:0] sec_addr_d8      = 32'h0000_00d8;
  localparam logic [boot_cfg_pkg::addr_w-1:0] sec_addr_ctrl    = 32'h0000_0000;

  localparam logic [boot_cfg_pkg::data_w-1:0] sec_val_div     = 32'h0000_0009;
  localparam logic [boot_cfg_pkg::data_w-1:0] sec_val_mode_70 = 32'h0000_6667;
  localparam logic [boot_cfg_pkg::data_w-1:0] sec_val_stat    = 32'h6666_6666;
  localparam logic [boot_cfg_pkg::data_w-1:0] sec_val_d8      = 32'h0000_0002;
  localparam logic [boot_cfg_pkg::data_w-1:0] sec_val_ctrl    = 32'hc100_0001;

  // mode bits 7:6 forced low
  localparam logic [boot_cfg_pkg::data_w-1:0] sec_rmw_clear = 32'h0000_00c0;

  // *********************************************************************
  // script tables
  // *********************************************************************
  localparam boot_cfg_pkg::script_t pri_script = '{
    boot_cfg_pkg::step_wr(pri_addr_cfg0, pri_val_cfg0),
    boot_cfg_pkg::step_wr(pri_addr_cfg1, pri_val_cfg1),
    boot_cfg_pkg::step_wr(pri_addr_timing, pri_val_timing),
    boot_cfg_pkg::step_wr(pri_addr_intr_en, pri_val_intr_en),
    boot_cfg_pkg::step_wr(pri_addr_ctrl, pri_val_ctrl),
    boot_cfg_pkg::step_wait(pri_boot_wait),
    boot_cfg_pkg::step_wr(pri_addr_cmd, pri_val_cmd),
    boot_cfg_pkg::step_wr(pri_addr_cmd, pri_val_cmd),
    boot_cfg_pkg::step_end,
    boot_cfg_pkg::step_end
  };

  localparam boot_cfg_pkg::script_t sec_script = '{
    boot_cfg_pkg::step_wr(sec_addr_div, sec_val_div),
    boot_cfg_pkg::step_rmw(sec_addr_mode_78, sec_rmw_clear),
    boot_cfg_pkg::step_wr(sec_addr_mode_70, sec_val_mode_70),
    boot_cfg_pkg::step_wr(sec_addr_stat, sec_val_stat),
    boot_cfg_pkg::step_wr(sec_addr_d8, sec_val_d8),
    // enable goes last
    boot_cfg_pkg::step_wr(sec_addr_ctrl, sec_val_ctrl),
    boot_cfg_pkg::step_end,
    boot_cfg_pkg::step_end,
    boot_cfg_pkg::step_end,
    boot_cfg_pkg::step_end
  };

endpackage

// File: logic/xfer_req_if.sv
// transfer request interface: single read or write requests from a script player to an APB engine
`timescale 1ns/1ns

interface xfer_req_if;

  // one-cycle request strobe, only when nothing is outstanding
  logic                            req;
  // 1 = write, 0 = read
  logic                            wr;
  // held by the player until done
  logic [boot_cfg_pkg::addr_w-1:0] addr;
  logic [boot_cfg_pkg::data_w-1:0] wdata;
  // one-cycle completion strobe, rdata valid with it
  logic                            done;
  logic [boot_cfg_pkg::data_w-1:0] rdata;

  modport player (
    output req, wr, addr, wdata,
    input  done, rdata
  );

  modport engine (
    input  req, wr, addr, wdata,
    output done, rdata
  );

endinterface

// File: logic/apb_xfer_engine.sv
// APB requester engine: runs one setup/access transfer per request and reports completion
`timescale 1ns/1ns

module apb_xfer_engine (
  input  logic                            clk_50m,
  input  logic                            chip_rst_l,
  xfer_req_if.engine                      req_port,
  output logic                            psel,
  output logic                            penable,
  output logic                            pwrite,
  output logic [boot_cfg_pkg::addr_w-1:0] paddr,
  output logic [boot_cfg_pkg::data_w-1:0] pwdata,
  input  logic                            pready,
  input  logic [boot_cfg_pkg::data_w-1:0] prdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } state_t;

  state_t state;

  // *********************************************************************
  // phase machine
  // *********************************************************************
  always_ff @(posedge clk_50m or negedge chip_rst_l) begin
    if (!chip_rst_l) begin
      state         <= st_idle;
      psel          <= 1'b0;
      penable       <= 1'b0;
      pwrite        <= 1'b0;
      paddr         <= '0;
      pwdata        <= '0;
      req_port.done <= 1'b0;
    end else begin
      // done is a single-cycle strobe
      req_port.done <= 1'b0;
      case (state)
        st_idle: begin
          // latch request straight into the bus, setup next cycle
          if (req_port.req) begin
            psel   <= 1'b1;
            pwrite <= req_port.wr;
            paddr  <= req_port.addr;
            pwdata <= req_port.wdata;
            state  <= st_setup;
          end
        end
        st_setup: begin
          penable <= 1'b1;
          state   <= st_access;
        end
        st_access: begin
          // pready low stretches access, everything holds
          if (pready) begin
            psel          <= 1'b0;
            penable       <= 1'b0;
            req_port.done <= 1'b1;
            state         <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // read data capture on the completing edge
  always_ff @(posedge clk_50m) begin
    if (state == st_access && pready) begin
      req_port.rdata <= prdata;
    end
  end

endmodule

// File: logic/script_player.sv
// script player: walks one boot script, issuing writes, read-modify-writes and idle waits
`timescale 1ns/1ns

module script_player #(
  parameter boot_cfg_pkg::script_t script = '{default: boot_cfg_pkg::step_end}
) (
  input  logic         clk_50m,
  input  logic         chip_rst_l,
  xfer_req_if.player   req_port,
  output logic         cfg_done
);

  typedef enum logic [2:0] {
    ph_issue,
    ph_wait_done,
    ph_rmw_rd,
    ph_rmw_wr,
    ph_count,
    ph_finished
  } phase_t;

  phase_t                              phase;
  logic [boot_cfg_pkg::step_idx_w-1:0] step_idx;
  logic [boot_cfg_pkg::wait_w-1:0]     wait_cnt;

  // start of a new step this edge
  logic                                launch;
  logic [boot_cfg_pkg::step_idx_w-1:0] launch_idx;
  boot_cfg_pkg::step_t                 launch_step;
  boot_cfg_pkg::step_t                 cur_step;

  assign cur_step = script[step_idx];

  // *********************************************************************
  // next step select
  // *********************************************************************
  always_comb begin
    // ph_issue only right after reset, starts at step 0
    // everywhere else the next step follows the current one
    launch = (phase == ph_issue) ||
             ((phase == ph_wait_done || phase == ph_rmw_wr) && req_port.done) ||
             (phase == ph_count && wait_cnt <= 'd1);
    if (phase == ph_issue) begin
      launch_idx  = step_idx;
      launch_step = script[step_idx];
    end else if (step_idx == boot_cfg_pkg::last_step) begin
      // ran off the table
      launch_idx  = step_idx;
      launch_step = boot_cfg_pkg::step_end;
    end else begin
      launch_idx  = step_idx + 1'b1;
      launch_step = script[launch_idx];
    end
  end

  // *********************************************************************
  // step sequencing
  // *********************************************************************
  always_ff @(posedge clk_50m or negedge chip_rst_l) begin
    if (!chip_rst_l) begin
      phase        <= ph_issue;
      step_idx     <= '0;
      wait_cnt     <= '0;
      req_port.req <= 1'b0;
      cfg_done     <= 1'b0;
    end else begin
      req_port.req <= 1'b0;
      if (launch) begin
        case (launch_step.op)
          boot_cfg_pkg::op_write: begin
            req_port.req <= 1'b1;
            step_idx     <= launch_idx;
            phase        <= ph_wait_done;
          end
          boot_cfg_pkg::op_rmw: begin
            // read half first
            req_port.req <= 1'b1;
            step_idx     <= launch_idx;
            phase        <= ph_rmw_rd;
          end
          boot_cfg_pkg::op_wait: begin
            wait_cnt <= launch_step.count;
            step_idx <= launch_idx;
            phase    <= ph_count;
          end
          default: begin
            // end step, done holds until reset
            cfg_done <= 1'b1;
            phase    <= ph_finished;
          end
        endcase
      end else if (phase == ph_rmw_rd && req_port.done) begin
        // write half goes out the cycle after read data
        req_port.req <= 1'b1;
        phase        <= ph_rmw_wr;
      end else if (phase == ph_count) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  // request fields, held until done
  always_ff @(posedge clk_50m) begin
    if (launch && (launch_step.op == boot_cfg_pkg::op_write ||
                   launch_step.op == boot_cfg_pkg::op_rmw)) begin
      req_port.wr    <= (launch_step.op == boot_cfg_pkg::op_write);
      req_port.addr  <= launch_step.addr;
      req_port.wdata <= launch_step.data;
    end else if (phase == ph_rmw_rd && req_port.done) begin
      // merge, same address as the read
      req_port.wr    <= 1'b1;
      req_port.wdata <= req_port.rdata & ~cur_step.mask;
    end
  end

endmodule

// File: logic/boot_seq_top.sv
// boot sequencer top: primary and secondary script players, each driving its own APB requester
`timescale 1ns/1ns

module boot_seq_top (
  input  logic                            clk_50m,
  input  logic                            chip_rst_l,
  // primary controller APB
  output logic                            pri_psel,
  output logic                            pri_penable,
  output logic                            pri_pwrite,
  output logic [boot_cfg_pkg::addr_w-1:0] pri_paddr,
  output logic [boot_cfg_pkg::data_w-1:0] pri_pwdata,
  input  logic                            pri_pready,
  input  logic [boot_cfg_pkg::data_w-1:0] pri_prdata,
  // secondary controller APB
  output logic                            sec_psel,
  output logic                            sec_penable,
  output logic                            sec_pwrite,
  output logic [boot_cfg_pkg::addr_w-1:0] sec_paddr,
  output logic [boot_cfg_pkg::data_w-1:0] sec_pwdata,
  input  logic                            sec_pready,
  input  logic [boot_cfg_pkg::data_w-1:0] sec_prdata,
  // script completion levels
  output logic                            pri_cfg_done,
  output logic                            sec_cfg_done
);

  xfer_req_if pri_req_if ();
  xfer_req_if sec_req_if ();

  // *********************************************************************
  // primary channel
  // *********************************************************************
  script_player #(
    .script (boot_scripts_pkg::pri_script)
  ) u_pri_player (
    .clk_50m    (clk_50m),
    .chip_rst_l (chip_rst_l),
    .req_port   (pri_req_if.player),
    .cfg_done   (pri_cfg_done)
  );

  apb_xfer_engine u_pri_engine (
    .clk_50m    (clk_50m),
    .chip_rst_l (chip_rst_l),
    .req_port   (pri_req_if.engine),
    .psel       (pri_psel),
    .penable    (pri_penable),
    .pwrite     (pri_pwrite),
    .paddr      (pri_paddr),
    .pwdata     (pri_pwdata),
    .pready     (pri_pready),
    .prdata     (pri_prdata)
  );

  // *********************************************************************
  // secondary channel, runs independently of primary
  // *********************************************************************
  script_player #(
    .script (boot_scripts_pkg::sec_script)
  ) u_sec_player (
    .clk_50m    (clk_50m),
    .chip_rst_l (chip_rst_l),
    .req_port   (sec_req_if.player),
    .cfg_done   (sec_cfg_done)
  );

  apb_xfer_engine u_sec_engine (
    .clk_50m    (clk_50m),
    .chip_rst_l (chip_rst_l),
    .req_port   (sec_req_if.engine),
    .psel       (sec_psel),
    .penable    (sec_penable),
    .pwrite     (sec_pwrite),
    .paddr      (sec_paddr),
    .pwdata     (sec_pwdata),
    .pready     (sec_pready),
    .prdata     (sec_prdata)
  );

endmodule

// File: tests/apb_resp_model.sv
// APB completer model: register memory, random wait states and a log of finished transfers
`timescale 1ns/1ns

module apb_resp_model #(
  parameter logic [31:0]                       seed_init    = 32'h0,
  parameter logic [boot_cfg_pkg::addr_w-1:0]   preload_addr = '0,
  parameter logic [boot_cfg_pkg::data_w-1:0]   preload_data = '0
) (
  input  logic                            clk_50m,
  input  logic                            chip_rst_l,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [boot_cfg_pkg::addr_w-1:0] paddr,
  input  logic [boot_cfg_pkg::data_w-1:0] pwdata,
  output logic                            pready,
  output logic [boot_cfg_pkg::data_w-1:0] prdata
);

  // word registers, paddr[9:2] covers everything up to 0x3fc
  logic [boot_cfg_pkg::data_w-1:0] mem [256];
  integer                          seed;
  logic [31:0]                     draw;
  logic [1:0]                      wait_left;

  // finished transfers, read back by the test tasks
  bit                              log_wr   [$];
  logic [boot_cfg_pkg::addr_w-1:0] log_addr [$];
  logic [boot_cfg_pkg::data_w-1:0] log_data [$];

  initial begin
    seed      = seed_init;
    pready    = 1'b0;
    prdata    = '0;
    wait_left = 2'd0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
    mem[preload_addr[9:2]] = preload_data;
  end

  // raise pready with read data for the held address
  task present_response;
    pready = 1'b1;
    prdata = pwrite ? '0 : mem[paddr[9:2]];
  endtask

  // *********************************************************************
  // completer phases, sampled on the rising edge, driven 1 ns later
  // *********************************************************************
  always @(posedge clk_50m) begin
    if (!chip_rst_l) begin
      #1;
      pready = 1'b0;
    end else if (psel && penable && pready) begin
      // completing edge
      if (pwrite) begin
        mem[paddr[9:2]] = pwdata;
      end
      log_wr.push_back(pwrite);
      log_addr.push_back(paddr);
      log_data.push_back(pwrite ? pwdata : prdata);
      #1;
      pready = 1'b0;
    end else if (psel && !penable) begin
      // setup seen, pick 0 to 3 wait states for the access phase
      draw      = $random(seed);
      wait_left = draw[1:0];
      #1;
      if (wait_left == 2'd0) begin
        present_response();
      end
    end else if (psel && penable) begin
      wait_left = wait_left - 2'd1;
      #1;
      if (wait_left == 2'd0) begin
        present_response();
      end
    end
  end

endmodule

// File: tests/boot_seq_props.sv
// APB protocol properties for one requester engine, bound onto every apb_xfer_engine
`timescale 1ns/1ns

module boot_seq_props (
  input logic                            clk_50m,
  input logic                            chip_rst_l,
  input logic                            psel,
  input logic                            penable,
  input logic                            pwrite,
  input logic [boot_cfg_pkg::addr_w-1:0] paddr,
  input logic [boot_cfg_pkg::data_w-1:0] pwdata,
  input logic                            pready,
  input logic                            done
);

  // failed assertion count, summed by the testbench
  int fail_cnt = 0;

  // *********************************************************************
  // bus phase rules
  // *********************************************************************
  a_enable_needs_sel : assert property (@(posedge clk_50m) disable iff (!chip_rst_l)
    penable |-> psel)
    else begin
      $error("penable high without psel");
      fail_cnt++;
    end

  // a new transfer always starts with a setup cycle
  a_setup_first : assert property (@(posedge clk_50m) disable iff (!chip_rst_l)
    $rose(psel) |-> !penable)
    else begin
      $error("psel rose together with penable");
      fail_cnt++;
    end

  // request fields frozen from setup until the completing edge
  a_fields_stable : assert property (@(posedge clk_50m) disable iff (!chip_rst_l)
    (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
    else begin
      $error("paddr, pwrite or pwdata changed inside a transfer");
      fail_cnt++;
    end

  // done strobe only once the bus is released
  a_done_after_bus : assert property (@(posedge clk_50m) disable iff (!chip_rst_l)
    !(done && psel))
    else begin
      $error("done strobe while psel still high");
      fail_cnt++;
    end

endmodule

bind apb_xfer_engine boot_seq_props u_props (
  .clk_50m    (clk_50m),
  .chip_rst_l (chip_rst_l),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .paddr      (paddr),
  .pwdata     (pwdata),
  .pready     (pready),
  .done       (req_port.done)
);

// File: tests/boot_seq_tb.sv
// boot sequencer testbench with directed checks of both scripts against two APB completer models
`timescale 1ns/1ns

module boot_seq_tb;

  localparam logic [31:0] rand_seed    = 32'hd83403e3;
  localparam logic [31:0] sec_preload  = 32'hc900_00ff;
  localparam int          reset_cycles = 8;
  localparam int          sec_timeout  = 5000;
  // primary script holds a 65535 cycle wait
  localparam int          pri_timeout  = 80000;
  localparam int          quiet_cycles = 200;

  logic                            clk_50m;
  logic                            chip_rst_l = 1'b0;
  logic                            pri_psel, pri_penable, pri_pwrite, pri_pready;
  logic [boot_cfg_pkg::addr_w-1:0] pri_paddr;
  logic [boot_cfg_pkg::data_w-1:0] pri_pwdata, pri_prdata;
  logic                            sec_psel, sec_penable, sec_pwrite, sec_pready;
  logic [boot_cfg_pkg::addr_w-1:0] sec_paddr;
  logic [boot_cfg_pkg::data_w-1:0] sec_pwdata, sec_prdata;
  logic                            pri_cfg_done, sec_cfg_done;

  int          errors = 0;
  int          assert_errors;
  // expected transfer list built from a script
  bit          exp_wr   [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  // idle cycles on pri_psel before each primary transfer
  int          pri_gaps [$];
  int          idle_run = 0;

  initial begin
    clk_50m = 1'b0;
    forever #10 clk_50m = ~clk_50m;
  end

  // *********************************************************************
  // DUT and completer models
  // *********************************************************************
  boot_seq_top DUT (
    .clk_50m (clk_50m), .chip_rst_l (chip_rst_l),
    .pri_psel (pri_psel), .pri_penable (pri_penable), .pri_pwrite (pri_pwrite),
    .pri_paddr (pri_paddr), .pri_pwdata (pri_pwdata),
    .pri_pready (pri_pready), .pri_prdata (pri_prdata),
    .sec_psel (sec_psel), .sec_penable (sec_penable), .sec_pwrite (sec_pwrite),
    .sec_paddr (sec_paddr), .sec_pwdata (sec_pwdata),
    .sec_pready (sec_pready), .sec_prdata (sec_prdata),
    .pri_cfg_done (pri_cfg_done), .sec_cfg_done (sec_cfg_done)
  );

  apb_resp_model #(.seed_init (rand_seed)) u_pri_model (
    .clk_50m (clk_50m), .chip_rst_l (chip_rst_l), .psel (pri_psel), .penable (pri_penable),
    .pwrite (pri_pwrite), .paddr (pri_paddr), .pwdata (pri_pwdata),
    .pready (pri_pready), .prdata (pri_prdata)
  );

  // mode register preloaded for the rmw step
  apb_resp_model #(
    .seed_init    (rand_seed),
    .preload_addr (boot_scripts_pkg::sec_addr_mode_78),
    .preload_data (sec_preload)
  ) u_sec_model (
    .clk_50m (clk_50m), .chip_rst_l (chip_rst_l), .psel (sec_psel), .penable (sec_penable),
    .pwrite (sec_pwrite), .paddr (sec_paddr), .pwdata (sec_pwdata),
    .pready (sec_pready), .prdata (sec_prdata)
  );

  always @(negedge clk_50m) begin
    if (!chip_rst_l) begin
      idle_run = 0;
    end else if (pri_psel) begin
      if (idle_run > 0) begin
        pri_gaps.push_back(idle_run);
      end
      idle_run = 0;
    end else begin
      idle_run++;
    end
  end

  // *********************************************************************
  // helpers
  // *********************************************************************
  task check_low(input string name, input logic val);
    if (val !== 1'b0) begin
      $display("Fail %s: got 0x%0h expected 0x0", name, val);
      errors++;
    end
  endtask

  // an rmw step expands into a read and a merged write
  task automatic expect_from_script(input boot_cfg_pkg::script_t script,
                                    input logic [31:0] pre_addr, input logic [31:0] pre_data);
    logic [31:0] rd;
    bit          stop;
    exp_wr.delete();
    exp_addr.delete();
    exp_data.delete();
    stop = 1'b0;
    for (int i = 0; i < boot_cfg_pkg::max_steps; i++) begin
      if (!stop) begin
        case (script[i].op)
          boot_cfg_pkg::op_write: begin
            exp_wr.push_back(1'b1);
            exp_addr.push_back(script[i].addr);
            exp_data.push_back(script[i].data);
          end
          boot_cfg_pkg::op_rmw: begin
            rd = (script[i].addr == pre_addr) ? pre_data : '0;
            // an earlier write to the same register wins
            foreach (exp_addr[j]) begin
              if (exp_wr[j] && exp_addr[j] == script[i].addr) begin
                rd = exp_data[j];
              end
            end
            exp_wr.push_back(1'b0);
            exp_addr.push_back(script[i].addr);
            exp_data.push_back(rd);
            exp_wr.push_back(1'b1);
            exp_addr.push_back(script[i].addr);
            exp_data.push_back(rd & ~script[i].mask);
          end
          boot_cfg_pkg::op_wait: begin
          end
          default: stop = 1'b1;
        endcase
      end
    end
  endtask

  task automatic check_entry(input string chan, input int idx, input bit ew,
                             input logic [31:0] ea, input logic [31:0] ed, input bit gw,
                             input logic [31:0] ga, input logic [31:0] gd);
    string sig;
    sig = ew ? "pwdata" : "prdata";
    if (gw !== ew) begin
      $display("Fail %s_pwrite[%0d]: got 0x%0h expected 0x%0h", chan, idx, gw, ew);
      errors++;
    end
    if (ga !== ea) begin
      $display("Fail %s_paddr[%0d]: got 0x%08h expected 0x%08h", chan, idx, ga, ea);
      errors++;
    end
    if (gd !== ed) begin
      $display("Fail %s_%s[%0d]: got 0x%08h expected 0x%08h", chan, sig, idx, gd, ed);
      errors++;
    end
  endtask

  // model log against the expected list
  task automatic compare_log(input bit pri);
    string       chan;
    int          n_got;
    bit          gw;
    logic [31:0] ga;
    logic [31:0] gd;
    chan  = pri ? "pri" : "sec";
    n_got = pri ? u_pri_model.log_addr.size() : u_sec_model.log_addr.size();
    if (n_got != exp_addr.size()) begin
      $display("Fail %s transfer count: got 0x%0h expected 0x%0h", chan, n_got, exp_addr.size());
      errors++;
    end
    for (int i = 0; i < n_got && i < exp_addr.size(); i++) begin
      if (pri) begin
        gw = u_pri_model.log_wr[i];
        ga = u_pri_model.log_addr[i];
        gd = u_pri_model.log_data[i];
      end else begin
        gw = u_sec_model.log_wr[i];
        ga = u_sec_model.log_addr[i];
        gd = u_sec_model.log_data[i];
      end
      check_entry(chan, i, exp_wr[i], exp_addr[i], exp_data[i], gw, ga, gd);
    end
  endtask

  // *********************************************************************
  // directed tests
  // *********************************************************************
  task check_reset;
    chip_rst_l = 1'b0;
    for (int i = 0; i < reset_cycles; i++) begin
      @(negedge clk_50m);
      check_low("pri_psel", pri_psel);
      check_low("sec_psel", sec_psel);
      check_low("pri_penable", pri_penable);
      check_low("sec_penable", sec_penable);
      check_low("pri_cfg_done", pri_cfg_done);
      check_low("sec_cfg_done", sec_cfg_done);
    end
    @(posedge clk_50m);
    #1 chip_rst_l = 1'b1;
    // bus still idle in the first cycle out of reset
    @(negedge clk_50m);
    check_low("pri_psel", pri_psel);
    check_low("sec_psel", sec_psel);
    check_low("pri_penable", pri_penable);
    check_low("sec_penable", sec_penable);
    check_low("pri_cfg_done", pri_cfg_done);
    check_low("sec_cfg_done", sec_cfg_done);
  endtask

  // done rises after the last transfer and then holds with a silent bus
  task automatic check_done_quiet(input bit pri);
    string chan;
    int    cycles;
    int    limit;
    int    n_got;
    bit    bad;
    chan  = pri ? "pri" : "sec";
    limit = pri ? pri_timeout : sec_timeout;
    if (pri) begin
      expect_from_script(boot_scripts_pkg::pri_script, '0, '0);
    end else begin
      expect_from_script(boot_scripts_pkg::sec_script, boot_scripts_pkg::sec_addr_mode_78,
                         sec_preload);
    end
    cycles = 0;
    @(negedge clk_50m);
    while (!(pri ? pri_cfg_done : sec_cfg_done) && cycles < limit) begin
      @(negedge clk_50m);
      cycles++;
    end
    if (!(pri ? pri_cfg_done : sec_cfg_done)) begin
      $display("%s cfg_done did not rise within %0d cycles", chan, limit);
      errors++;
    end else begin
      n_got = pri ? u_pri_model.log_addr.size() : u_sec_model.log_addr.size();
      if (n_got != exp_addr.size()) begin
        $display("Fail %s transfers at cfg_done: got 0x%0h expected 0x%0h",
                 chan, n_got, exp_addr.size());
        errors++;
      end
      bad = 1'b0;
      for (int i = 0; i < quiet_cycles && !bad; i++) begin
        @(negedge clk_50m);
        if (pri ? pri_psel : sec_psel) begin
          $display("%s psel went active after cfg_done", chan);
          errors++;
          bad = 1'b1;
        end else if (!(pri ? pri_cfg_done : sec_cfg_done)) begin
          $display("%s cfg_done dropped before reset", chan);
          errors++;
          bad = 1'b1;
        end
      end
    end
  endtask

  task check_sec_log;
    int rd_idx;
    int last;
    expect_from_script(boot_scripts_pkg::sec_script, boot_scripts_pkg::sec_addr_mode_78,
                       sec_preload);
    compare_log(1'b0);
    // merged write follows the mode read directly
    rd_idx = -1;
    foreach (u_sec_model.log_addr[i]) begin
      if (rd_idx < 0 && !u_sec_model.log_wr[i] &&
          u_sec_model.log_addr[i] == boot_scripts_pkg::sec_addr_mode_78) begin
        rd_idx = i;
      end
    end
    if (rd_idx < 0 || rd_idx + 1 >= u_sec_model.log_addr.size()) begin
      $display("secondary mode register read and write back not seen");
      errors++;
    end else if (u_sec_model.log_data[rd_idx + 1] !==
                 (sec_preload & ~boot_scripts_pkg::sec_rmw_clear)) begin
      $display("Fail sec_pwdata merged: got 0x%08h expected 0x%08h",
               u_sec_model.log_data[rd_idx + 1], sec_preload & ~boot_scripts_pkg::sec_rmw_clear);
      errors++;
    end
    last = u_sec_model.log_addr.size() - 1;
    if (last >= 0 && u_sec_model.log_data[last] !== boot_scripts_pkg::sec_val_ctrl) begin
      $display("Fail sec_pwdata last: got 0x%08h expected 0x%08h",
               u_sec_model.log_data[last], boot_scripts_pkg::sec_val_ctrl);
      errors++;
    end
  endtask

  task check_pri_log;
    expect_from_script(boot_scripts_pkg::pri_script, '0, '0);
    compare_log(1'b1);
  endtask

  // idle gap ahead of the first transfer after the wait step
  task check_pri_wait;
    int n_before;
    int wait_len;
    bit found;
    n_before = 0;
    wait_len = 0;
    found    = 1'b0;
    foreach (boot_scripts_pkg::pri_script[i]) begin
      if (!found) begin
        if (boot_scripts_pkg::pri_script[i].op == boot_cfg_pkg::op_wait) begin
          found    = 1'b1;
          wait_len = boot_scripts_pkg::pri_script[i].count;
        end else if (boot_scripts_pkg::pri_script[i].op == boot_cfg_pkg::op_write) begin
          n_before++;
        end else if (boot_scripts_pkg::pri_script[i].op == boot_cfg_pkg::op_rmw) begin
          n_before += 2;
        end
      end
    end
    if (!found) begin
      $display("primary script holds no wait step");
      errors++;
    end else if (pri_gaps.size() <= n_before) begin
      $display("no primary transfer seen after the wait step");
      errors++;
    end else if (pri_gaps[n_before] < wait_len) begin
      $display("Fail pri_psel idle cycles: got 0x%0h expected at least 0x%0h",
               pri_gaps[n_before], wait_len);
      errors++;
    end
  endtask

  // *********************************************************************
  // main sequence
  // *********************************************************************
  initial begin
    chip_rst_l = 1'b0;
    check_reset();
    check_done_quiet(1'b0);
    check_sec_log();
    check_done_quiet(1'b1);
    check_pri_log();
    check_pri_wait();
    assert_errors = DUT.u_pri_engine.u_props.fail_cnt + DUT.u_sec_engine.u_props.fail_cnt;
    $display("boot_seq_tb done: %0d check errors, %0d assertion errors", errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
logic/boot_cfg_pkg.sv
logic/boot_scripts_pkg.sv
logic/xfer_req_if.sv
logic/apb_xfer_engine.sv
logic/script_player.sv
logic/boot_seq_top.sv
tests/apb_resp_model.sv
tests/boot_seq_props.sv
tests/boot_seq_tb.sv
